// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
	parameter int LINES = 8
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    core_req_i,
	input  logic                    core_rw_i,
	input  lease_cache_pkg::waddr_t core_addr_i,
	input  lease_cache_pkg::word_t  core_wdata_i,
	output logic                    core_ack_o,
	output lease_cache_pkg::word_t  core_rdata_o,
	output logic                    core_hit_o,
	output logic                    flag_hit_o,
	output logic                    flag_miss_o,
	output logic                    flag_writeback_o,
	output logic                    flag_expired_o,
	tag_if.ctrl                     tag_p,
	data_if.ctrl                    data_p,
	lease_if.ctrl                   lease_p,
	mem_cmd_if.ctrl                 mem_p
);
	import lease_cache_pkg::*;

	localparam int IDX_BITS = (LINES > 1) ? $clog2(LINES) : 1;
	typedef logic [IDX_BITS-1:0] idx_t;

	ctrl_state_t      state_q;
	logic [LINES-1:0] dirty_q;       // line differs from memory
	waddr_t           req_addr_q;    // request latched on miss
	logic             req_rw_q;
	word_t            req_wdata_q;
	idx_t             victim_q;
	word_off_t        xfer_q;        // words moved in current block
	logic             start_q;
	logic             mem_rw_q;
	blk_addr_t        mem_blk_q;
	logic             core_ack_q;
	logic             core_hit_q;
	word_t            core_rdata_q;
	logic             fl_hit_q, fl_miss_q, fl_wb_q, fl_exp_q;
	logic             hit_now, miss_now, fill_done;

	// ----------------------------------------
	// request decode
	// ----------------------------------------
	assign hit_now   = (state_q == ST_NORMAL) && core_req_i && tag_p.hit;
	assign miss_now  = (state_q == ST_NORMAL) && core_req_i && !tag_p.hit;
	assign fill_done = (state_q == ST_FILL) && mem_p.done;  // block in, serve as hit

	assign tag_p.lookup_tag = core_addr_i[WADDR_BITS-1:BLOCK_BITS];
	assign tag_p.wr_en      = fill_done;
	assign tag_p.wr_idx     = (state_q == ST_WAIT_VICTIM) ? lease_p.victim_idx : victim_q;
	assign tag_p.wr_tag     = req_addr_q[WADDR_BITS-1:BLOCK_BITS];

	assign lease_p.access     = hit_now || fill_done;
	assign lease_p.access_idx = hit_now ? tag_p.hit_idx : victim_q;
	assign lease_p.victim_req = miss_now;  // answer lands in ST_WAIT_VICTIM

	assign mem_p.start = start_q;
	assign mem_p.rw    = mem_rw_q;
	assign mem_p.blk   = mem_blk_q;
	assign mem_p.wdata = data_p.rdata;  // write-back word, same cycle as rd_word

	// line store port mux
	always_comb begin
		data_p.addr  = {victim_q, req_addr_q[BLOCK_BITS-1:0]};
		data_p.we    = 1'b0;
		data_p.wdata = req_wdata_q;
		case (state_q)
			ST_NORMAL: begin
				data_p.addr  = {tag_p.hit_idx, core_addr_i[BLOCK_BITS-1:0]};
				data_p.we    = hit_now && core_rw_i;
				data_p.wdata = core_wdata_i;
			end
			ST_WRITEBACK: data_p.addr = {victim_q, mem_p.word_idx};
			ST_FILL: if (fill_done) begin
				data_p.we = req_rw_q;  // pending store lands in new line
			end else begin
				data_p.addr  = {victim_q, mem_p.word_idx};
				data_p.we    = mem_p.wr_word;
				data_p.wdata = mem_p.rdata;
			end
			default: ;
		endcase
	end

	// ----------------------------------------
	// main FSM
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= ST_NORMAL;
			dirty_q    <= '0;
			xfer_q     <= '0;
			start_q    <= 1'b0;
			core_ack_q <= 1'b0;
			fl_hit_q   <= 1'b0;
			fl_miss_q  <= 1'b0;
			fl_wb_q    <= 1'b0;
			fl_exp_q   <= 1'b0;
		end else begin
			start_q   <= 1'b0;
			fl_hit_q  <= 1'b0;
			fl_miss_q <= 1'b0;
			fl_wb_q   <= 1'b0;
			fl_exp_q  <= 1'b0;
			if (mem_p.rd_word || mem_p.wr_word)
				xfer_q <= xfer_q + 1'b1;
			case (state_q)
				ST_NORMAL: if (hit_now) begin
					core_ack_q   <= 1'b1;
					core_hit_q   <= 1'b1;
					core_rdata_q <= core_rw_i ? core_wdata_i : data_p.rdata;
					fl_hit_q     <= 1'b1;
					if (core_rw_i)
						dirty_q[tag_p.hit_idx] <= 1'b1;
					state_q <= ST_REPLY;
				end else if (miss_now) begin
					req_addr_q  <= core_addr_i;
					req_rw_q    <= core_rw_i;
					req_wdata_q <= core_wdata_i;
					fl_miss_q   <= 1'b1;
					state_q     <= ST_WAIT_VICTIM;
				end
				ST_WAIT_VICTIM: if (lease_p.victim_valid) begin
					victim_q <= lease_p.victim_idx;
					fl_exp_q <= lease_p.expired;
					start_q  <= 1'b1;
					xfer_q   <= '0;
					if (dirty_q[lease_p.victim_idx]) begin
						mem_rw_q  <= 1'b1;
						mem_blk_q <= tag_p.idx_tag;  // old block address
						fl_wb_q   <= 1'b1;
						state_q   <= ST_WRITEBACK;
					end else begin
						mem_rw_q  <= 1'b0;
						mem_blk_q <= req_addr_q[WADDR_BITS-1:BLOCK_BITS];
						state_q   <= ST_FILL;
					end
				end
				ST_WRITEBACK: if (mem_p.done) begin
					start_q           <= 1'b1;  // chain straight into fill
					xfer_q            <= '0;
					mem_rw_q          <= 1'b0;
					mem_blk_q         <= req_addr_q[WADDR_BITS-1:BLOCK_BITS];
					dirty_q[victim_q] <= 1'b0;
					state_q           <= ST_FILL;
				end
				ST_FILL: if (fill_done) begin
					dirty_q[victim_q] <= req_rw_q;
					core_ack_q        <= 1'b1;
					core_hit_q        <= 1'b0;
					core_rdata_q      <= req_rw_q ? req_wdata_q : data_p.rdata;
					state_q           <= ST_REPLY;
				end
				ST_REPLY: if (!core_req_i) begin
					core_ack_q <= 1'b0;  // close four-phase cycle
					state_q    <= ST_NORMAL;
				end
				default: state_q <= ST_NORMAL;
			endcase
		end
	end

	assign core_ack_o       = core_ack_q;
	assign core_hit_o       = core_hit_q;
	assign core_rdata_o     = core_rdata_q;
	assign flag_hit_o       = fl_hit_q;
	assign flag_miss_o      = fl_miss_q;
	assign flag_writeback_o = fl_wb_q;
	assign flag_expired_o   = fl_exp_q;

	a_ack_needs_req: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$rose(core_ack_o) |-> $past(core_req_i));
	// engine word order matches own word count
	a_word_order: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(mem_p.rd_word || mem_p.wr_word) |-> (mem_p.word_idx == xfer_q));

endmodule

// ==== lease_cache_ifs.sv ====
`timescale 1ns/1ps

// controller <-> tag store
interface tag_if #(
	parameter int LINES = 8
);
	import lease_cache_pkg::*;

	localparam int IDX_BITS = (LINES > 1) ? $clog2(LINES) : 1;

	tag_t                lookup_tag;  // tag of the core address
	logic                wr_en;       // install strobe
	logic [IDX_BITS-1:0] wr_idx;      // also selects idx_tag
	tag_t                wr_tag;
	logic                hit;
	logic [IDX_BITS-1:0] hit_idx;
	tag_t                idx_tag;     // tag held at wr_idx, for write-back address

	modport ctrl (output lookup_tag, wr_en, wr_idx, wr_tag, input hit, hit_idx, idx_tag);
	modport cam (input lookup_tag, wr_en, wr_idx, wr_tag, output hit, hit_idx, idx_tag);
endinterface

// controller <-> line data store
interface data_if #(
	parameter int LINES = 8
);
	import lease_cache_pkg::*;

	localparam int IDX_BITS = (LINES > 1) ? $clog2(LINES) : 1;

	logic [IDX_BITS+BLOCK_BITS-1:0] addr;  // {line, offset}
	logic                           we;
	word_t                          wdata;
	word_t                          rdata;  // combinational

	modport ctrl (output addr, we, wdata, input rdata);
	modport mem (input addr, we, wdata, output rdata);
endinterface

// controller <-> lease policy
interface lease_if #(
	parameter int LINES = 8
);
	localparam int IDX_BITS = (LINES > 1) ? $clog2(LINES) : 1;

	logic                access;        // line touched, renew its lease
	logic [IDX_BITS-1:0] access_idx;
	logic                victim_req;    // answered one cycle later
	logic                victim_valid;
	logic [IDX_BITS-1:0] victim_idx;
	logic                expired;       // victim lease had run out

	modport ctrl (output access, access_idx, victim_req, input victim_valid, victim_idx, expired);
	modport policy (input access, access_idx, victim_req, output victim_valid, victim_idx, expired);
endinterface

// controller <-> memory block engine
interface mem_cmd_if;
	import lease_cache_pkg::*;

	logic      start;     // one cycle strobe
	logic      rw;        // 1 = write-back, 0 = fill
	blk_addr_t blk;
	word_off_t word_idx;  // current word of the block
	logic      wr_word;   // fill word valid on rdata
	word_t     rdata;
	logic      rd_word;   // write-back word wanted on wdata, same cycle
	word_t     wdata;
	logic      done;

	modport ctrl (output start, rw, blk, wdata, input word_idx, wr_word, rdata, rd_word, done);
	modport port (input start, rw, blk, wdata, output word_idx, wr_word, rdata, rd_word, done);
endinterface

// ==== lease_cache_pkg.sv ====
package lease_cache_pkg;

	// ----------------------------------------
	// word and address widths
	// ----------------------------------------
	localparam int WADDR_BITS  = 16;          // word address into external memory
	localparam int BLOCK_BITS  = 2;           // word offset inside a block
	localparam int BLOCK_WORDS = 1 << BLOCK_BITS;
	localparam int TAG_BITS    = WADDR_BITS - BLOCK_BITS;  // fully associative, no group field

	typedef logic [31:0]             word_t;
	typedef logic [WADDR_BITS-1:0]   waddr_t;
	typedef logic [BLOCK_BITS-1:0]   word_off_t;
	typedef logic [TAG_BITS-1:0]     tag_t;
	typedef tag_t                    blk_addr_t;  // block start, same bits as the tag

	// ----------------------------------------
	// controller states
	// ----------------------------------------
	typedef enum logic [2:0] {
		ST_NORMAL,       // hit/miss check on core request
		ST_WAIT_VICTIM,  // policy picks the line to replace
		ST_WRITEBACK,    // dirty victim goes out
		ST_FILL,         // new block comes in
		ST_REPLY         // ack held until core drops req
	} ctrl_state_t;

endpackage

// ==== lease_cache_top.sv ====
`timescale 1ns/1ps

module lease_cache_top #(
	parameter int LINES         = 8,
	parameter int LEASE_DEFAULT = 3
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	// core side
	input  logic                    core_req_i,
	input  logic                    core_rw_i,     // 1 = store
	input  lease_cache_pkg::waddr_t core_addr_i,
	input  lease_cache_pkg::word_t  core_wdata_i,
	output logic                    core_ack_o,
	output lease_cache_pkg::word_t  core_rdata_o,
	output logic                    core_hit_o,
	// memory side, one handshake per word
	output logic                    mem_req_o,
	output logic                    mem_rw_o,
	output lease_cache_pkg::waddr_t mem_addr_o,
	output lease_cache_pkg::word_t  mem_wdata_o,
	input  logic                    mem_ack_i,
	input  lease_cache_pkg::word_t  mem_rdata_i,
	// performance pulses
	output logic                    flag_hit_o,
	output logic                    flag_miss_o,
	output logic                    flag_writeback_o,
	output logic                    flag_expired_o
);
	tag_if   #(.LINES(LINES)) tag_bus ();
	data_if  #(.LINES(LINES)) data_bus ();
	lease_if #(.LINES(LINES)) lease_bus ();
	mem_cmd_if                mem_cmd ();

	cache_ctrl #(.LINES(LINES)) ctrl0 (
		.clock_i, .resetn_i,
		.core_req_i, .core_rw_i, .core_addr_i, .core_wdata_i,
		.core_ack_o, .core_rdata_o, .core_hit_o,
		.flag_hit_o, .flag_miss_o, .flag_writeback_o, .flag_expired_o,
		.tag_p(tag_bus.ctrl), .data_p(data_bus.ctrl),
		.lease_p(lease_bus.ctrl), .mem_p(mem_cmd.ctrl)
	);

	tag_cam #(.LINES(LINES)) cam0 (.clock_i, .resetn_i, .tag_p(tag_bus.cam));

	line_store #(.LINES(LINES)) store0 (.clock_i, .data_p(data_bus.mem));

	lease_policy #(.LINES(LINES), .LEASE_DEFAULT(LEASE_DEFAULT)) policy0 (
		.clock_i, .resetn_i, .lease_p(lease_bus.policy)
	);

	mem_port port0 (
		.clock_i, .resetn_i,
		.mem_req_o, .mem_rw_o, .mem_addr_o, .mem_wdata_o, .mem_ack_i, .mem_rdata_i,
		.cmd_p(mem_cmd.port)
	);

endmodule

// ==== lease_policy.sv ====
`timescale 1ns/1ps

module lease_policy #(
	parameter int LINES         = 8,
	parameter int LEASE_DEFAULT = 3
)(
	input  logic    clock_i,
	input  logic    resetn_i,
	lease_if.policy lease_p
);
	localparam int IDX_BITS   = (LINES > 1) ? $clog2(LINES) : 1;
	localparam int LEASE_BITS = (LEASE_DEFAULT < 1) ? 1 : $clog2(LEASE_DEFAULT + 1);
	typedef logic [IDX_BITS-1:0]   idx_t;
	typedef logic [LEASE_BITS-1:0] lease_t;

	lease_t lease_q [LINES];
	idx_t   rr_q;          // fallback pointer when nothing expired
	logic   zero_found;
	idx_t   zero_idx;      // lowest line with lease 0
	logic   victim_valid_q;
	logic   expired_q;
	idx_t   victim_idx_q;

	// descending scan, lowest index wins
	always_comb begin
		zero_found = 1'b0;
		zero_idx   = '0;
		for (int i = LINES - 1; i >= 0; i--) begin
			if (lease_q[i] == '0) begin
				zero_found = 1'b1;
				zero_idx   = idx_t'(i);
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < LINES; i++)
				lease_q[i] <= '0;
			rr_q           <= '0;
			victim_valid_q <= 1'b0;
			expired_q      <= 1'b0;
		end else begin
			victim_valid_q <= lease_p.victim_req;  // answer one cycle later
			if (lease_p.access) begin
				for (int i = 0; i < LINES; i++) begin
					if (idx_t'(i) == lease_p.access_idx)
						lease_q[i] <= lease_t'(LEASE_DEFAULT);  // renew
					else if (lease_q[i] != '0)
						lease_q[i] <= lease_q[i] - 1'b1;       // age the rest
				end
			end
			if (lease_p.victim_req) begin
				expired_q <= zero_found;
				if (zero_found) begin
					victim_idx_q <= zero_idx;
				end else begin
					victim_idx_q <= rr_q;
					rr_q <= (rr_q == idx_t'(LINES - 1)) ? '0 : rr_q + 1'b1;
				end
			end
		end
	end

	assign lease_p.victim_valid = victim_valid_q;
	assign lease_p.victim_idx   = victim_idx_q;
	assign lease_p.expired      = expired_q;

	// no lease renewal between request and answer
	a_victim_lease: assert property (@(posedge clock_i) disable iff (!resetn_i)
		lease_p.victim_valid |-> (lease_p.expired ? (lease_q[lease_p.victim_idx] == '0)
			: !zero_found));

endmodule

// ==== line_store.sv ====
`timescale 1ns/1ps

module line_store #(
	parameter int LINES = 8
)(
	input  logic clock_i,
	data_if.mem  data_p
);
	import lease_cache_pkg::*;

	localparam int DEPTH = LINES * BLOCK_WORDS;  // one entry per cached word

	word_t mem_q [DEPTH];

	// ----------------------------------------
	// read is combinational, write on edge
	// ----------------------------------------
	assign data_p.rdata = mem_q[data_p.addr];

	always_ff @(posedge clock_i) begin
		if (data_p.we)
			mem_q[data_p.addr] <= data_p.wdata;  // fill word or core store
	end

endmodule

// ==== mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
	input  logic                    clock_i,
	input  logic                    resetn_i,
	output logic                    mem_req_o,
	output logic                    mem_rw_o,
	output lease_cache_pkg::waddr_t mem_addr_o,
	output lease_cache_pkg::word_t  mem_wdata_o,
	input  logic                    mem_ack_i,
	input  lease_cache_pkg::word_t  mem_rdata_i,
	mem_cmd_if.port                 cmd_p
);
	import lease_cache_pkg::*;

	typedef enum logic [1:0] {
		PS_IDLE,      // wait for start
		PS_ISSUE,     // load word, raise req
		PS_WAIT_ACK,  // req high until ack
		PS_WAIT_REL   // req low until ack drops
	} port_state_t;

	port_state_t state_q;
	blk_addr_t   blk_q;
	word_off_t   off_q;
	logic        rw_q;
	logic        req_q;
	logic        wr_word_q;
	logic        done_q;
	word_t       wdata_q;
	word_t       rdata_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q   <= PS_IDLE;
			req_q     <= 1'b0;
			wr_word_q <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			wr_word_q <= 1'b0;
			done_q    <= 1'b0;
			case (state_q)
				PS_IDLE: if (cmd_p.start) begin
					blk_q   <= cmd_p.blk;
					rw_q    <= cmd_p.rw;
					off_q   <= '0;  // block base first
					state_q <= PS_ISSUE;
				end
				PS_ISSUE: begin
					wdata_q <= cmd_p.wdata;  // line word, only used on write-back
					req_q   <= 1'b1;
					state_q <= PS_WAIT_ACK;
				end
				PS_WAIT_ACK: if (mem_ack_i) begin
					req_q     <= 1'b0;
					rdata_q   <= mem_rdata_i;
					wr_word_q <= !rw_q;  // hand fill word to controller
					state_q   <= PS_WAIT_REL;
				end
				PS_WAIT_REL: if (!mem_ack_i) begin
					if (off_q == word_off_t'(BLOCK_WORDS - 1)) begin
						done_q  <= 1'b1;
						state_q <= PS_IDLE;
					end else begin
						off_q   <= off_q + 1'b1;
						state_q <= PS_ISSUE;
					end
				end
				default: state_q <= PS_IDLE;
			endcase
		end
	end

	assign mem_req_o      = req_q;
	assign mem_rw_o       = rw_q;
	assign mem_addr_o     = {blk_q, off_q};
	assign mem_wdata_o    = wdata_q;
	assign cmd_p.word_idx = off_q;
	assign cmd_p.wr_word  = wr_word_q;
	assign cmd_p.rdata    = rdata_q;
	assign cmd_p.rd_word  = (state_q == PS_ISSUE) && rw_q;
	assign cmd_p.done     = done_q;

	// memory acks only a raised req
	a_ack_needs_req: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$rose(mem_ack_i) |-> mem_req_o);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lease cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_lease_cache -o sim_lease_cache

output=$(./obj_dir/sim_lease_cache)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
	exit 0
else
	exit 1
fi

// ==== tag_cam.sv ====
`timescale 1ns/1ps

module tag_cam #(
	parameter int LINES = 8
)(
	input  logic clock_i,
	input  logic resetn_i,
	tag_if.cam   tag_p
);
	import lease_cache_pkg::*;

	localparam int IDX_BITS = (LINES > 1) ? $clog2(LINES) : 1;
	typedef logic [IDX_BITS-1:0] idx_t;

	tag_t             tag_q [LINES];
	logic [LINES-1:0] valid_q;
	logic             dup_tags;  // two valid lines with one tag

	// parallel compare, all lines at once
	always_comb begin
		tag_p.hit     = 1'b0;
		tag_p.hit_idx = '0;
		for (int i = 0; i < LINES; i++) begin
			if (valid_q[i] && (tag_q[i] == tag_p.lookup_tag) && !tag_p.hit) begin
				tag_p.hit     = 1'b1;
				tag_p.hit_idx = idx_t'(i);
			end
		end
	end

	assign tag_p.idx_tag = tag_q[tag_p.wr_idx];  // victim tag for write-back

	always_ff @(posedge clock_i) begin
		if (tag_p.wr_en)
			tag_q[tag_p.wr_idx] <= tag_p.wr_tag;
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;  // all lines empty
		end else if (tag_p.wr_en) begin
			valid_q[tag_p.wr_idx] <= 1'b1;
		end
	end

	always_comb begin
		dup_tags = 1'b0;
		for (int i = 0; i < LINES; i++)
			for (int j = i + 1; j < LINES; j++)
				if (valid_q[i] && valid_q[j] && (tag_q[i] == tag_q[j]))
					dup_tags = 1'b1;
	end

	// controller only installs a tag after a miss on it
	a_unique_tags: assert property (@(posedge clock_i) disable iff (!resetn_i) !dup_tags);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40
)(
	output logic clock_o
);
	initial begin
		clock_o = 1'b0;
		forever #(PERIOD_NS / 2) clock_o = ~clock_o;  // 50% duty
	end

endmodule

// ==== tb_lease_cache.sv ====
`timescale 1ns/1ps

module tb_lease_cache;
	import lease_cache_pkg::*;

	localparam int LINES         = 8;
	localparam int LEASE_DEFAULT = 3;
	localparam int ACK_LIMIT     = 200;  // worst miss is write-back plus fill
	localparam int MEM_WORDS     = 1 << WADDR_BITS;

	typedef struct packed {
		logic   rw;           // 1 = store
		waddr_t addr;
		word_t  wdata;
		logic   exp_hit;
		logic   exp_wb;       // dirty victim goes out first
		logic   exp_expired;
		word_t  exp_rdata;
	} op_t;

	typedef enum {MS_IDLE, MS_DELAY, MS_ACK} mem_state_t;

	logic   clock, resetn;
	logic   core_req, core_rw, core_ack, core_hit;
	waddr_t core_addr;
	word_t  core_wdata, core_rdata;
	logic   mem_req, mem_rw, mem_ack;
	waddr_t mem_addr;
	word_t  mem_wdata, mem_rdata;
	logic   flag_hit, flag_miss, flag_wb, flag_exp;

	op_t    ops [$];
	int     errors, checks, ops_done;
	logic   timed_out;
	int     hit_pulses, miss_pulses, wb_pulses, exp_pulses;
	int     rd_words, wr_words;          // memory side word count
	word_t  mem_array [MEM_WORDS];       // external memory contents
	word_t  shadow [MEM_WORDS];          // stores that the core has seen acked

	// reference model state
	tag_t   m_tag [LINES];
	logic   m_valid [LINES];
	logic   m_dirty [LINES];
	int     m_lease [LINES];
	int     m_rr;
	word_t  m_mem [MEM_WORDS];

	tb_clock_gen #(.PERIOD_NS(40)) clk0 (.clock_o(clock));

	lease_cache_top #(.LINES(LINES), .LEASE_DEFAULT(LEASE_DEFAULT)) dut0 (
		.clock_i(clock), .resetn_i(resetn),
		.core_req_i(core_req), .core_rw_i(core_rw), .core_addr_i(core_addr),
		.core_wdata_i(core_wdata), .core_ack_o(core_ack), .core_rdata_o(core_rdata),
		.core_hit_o(core_hit),
		.mem_req_o(mem_req), .mem_rw_o(mem_rw), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
		.flag_hit_o(flag_hit), .flag_miss_o(flag_miss),
		.flag_writeback_o(flag_wb), .flag_expired_o(flag_exp)
	);

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// whole address in both halves
	function automatic word_t init_word(waddr_t a);
		return {a ^ 16'h5ac3, a};
	endfunction

	// ----------------------------------------
	// memory model, four-phase per word
	// ----------------------------------------
	task automatic answer_word();
		if (mem_rw === 1'b1) begin
			check_word("mem_wdata_o", mem_wdata, shadow[mem_addr]);  // dirty word out
			mem_array[mem_addr] = mem_wdata;
			wr_words++;
		end else begin
			mem_rdata = mem_array[mem_addr];
			rd_words++;
		end
		mem_ack = 1'b1;
	endtask

	initial begin
		mem_state_t mstate;
		int         delay;
		void'($urandom(8043));
		mem_ack   = 1'b0;
		mem_rdata = '0;
		mstate    = MS_IDLE;
		delay     = 0;
		for (int a = 0; a < MEM_WORDS; a++)
			mem_array[a] = init_word(waddr_t'(a));
		forever begin
			@(negedge clock);
			if (mstate == MS_IDLE && mem_req === 1'b1) begin
				delay  = int'($urandom % 4);  // 0..3 cycles of back-pressure
				mstate = MS_DELAY;
			end
			if (mstate == MS_DELAY) begin
				if (delay == 0) begin
					answer_word();
					mstate = MS_ACK;
				end else begin
					delay--;
				end
			end else if (mstate == MS_ACK && mem_req === 1'b0) begin
				mem_ack = 1'b0;  // close the word
				mstate  = MS_IDLE;
			end
		end
	end

	// pulse counters, sampled mid-cycle
	always @(negedge clock) begin
		if (flag_hit)  hit_pulses++;
		if (flag_miss) miss_pulses++;
		if (flag_wb)   wb_pulses++;
		if (flag_exp)  exp_pulses++;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic op_t predict(op_t op);
		tag_t blk;
		int   idx;
		blk            = op.addr[WADDR_BITS-1:BLOCK_BITS];
		idx            = -1;
		op.exp_wb      = 1'b0;
		op.exp_expired = 1'b0;
		for (int i = 0; i < LINES; i++)
			if (m_valid[i] && m_tag[i] == blk)
				idx = i;
		op.exp_hit = (idx >= 0);
		if (idx < 0) begin
			for (int i = LINES - 1; i >= 0; i--)
				if (m_lease[i] == 0)
					idx = i;  // lowest lease-0 line
			if (idx >= 0) begin
				op.exp_expired = 1'b1;
			end else begin
				idx  = m_rr;  // nothing expired, round-robin
				m_rr = (m_rr + 1) % LINES;
			end
			op.exp_wb    = m_valid[idx] && m_dirty[idx];
			m_tag[idx]   = blk;
			m_valid[idx] = 1'b1;
			m_dirty[idx] = 1'b0;
		end
		for (int i = 0; i < LINES; i++) begin
			if (i == idx)
				m_lease[i] = LEASE_DEFAULT;
			else if (m_lease[i] > 0)
				m_lease[i]--;
		end
		if (op.rw) begin
			m_dirty[idx]   = 1'b1;
			m_mem[op.addr] = op.wdata;
		end
		op.exp_rdata = m_mem[op.addr];
		return op;
	endfunction

	function automatic void add_op(logic rw, waddr_t addr, word_t wdata);
		op_t op;
		op       = '0;
		op.rw    = rw;
		op.addr  = addr;
		op.wdata = wdata;
		ops.push_back(op);
	endfunction

	// ----------------------------------------
	// core driver
	// ----------------------------------------
	task automatic wait_ack(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (core_ack !== level && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (core_ack !== level) begin
			$display("timeout at %0t: core_ack_o did not go %0b within %0d cycles",
				$time, level, limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_op(input int i);
		op_t op;
		int  cycles;
		int  err0, hit0, miss0, wb0, exp0, rd0, wr0;
		op    = ops[i];
		err0  = errors;
		hit0  = hit_pulses;
		miss0 = miss_pulses;
		wb0   = wb_pulses;
		exp0  = exp_pulses;
		rd0   = rd_words;
		wr0   = wr_words;
		core_rw    = op.rw;
		core_addr  = op.addr;
		core_wdata = op.wdata;
		core_req   = 1'b1;
		wait_ack(1'b1, ACK_LIMIT, cycles);
		if (!timed_out) begin
			check_bit("core_hit_o", core_hit, op.exp_hit);
			if (op.exp_hit)
				check_count("hit ack latency", cycles, 1);
			if (op.rw)
				shadow[op.addr] = op.wdata;
			else
				check_word("core_rdata_o", core_rdata, op.exp_rdata);
			core_req = 1'b0;
			wait_ack(1'b0, 4, cycles);
		end
		if (!timed_out) begin
			// all pulses of this op are over once ack is low
			check_count("flag_hit_o pulses", hit_pulses - hit0, int'(op.exp_hit));
			check_count("flag_miss_o pulses", miss_pulses - miss0, int'(!op.exp_hit));
			check_count("flag_writeback_o pulses", wb_pulses - wb0, int'(op.exp_wb));
			check_count("flag_expired_o pulses", exp_pulses - exp0,
				int'(!op.exp_hit && op.exp_expired));
			check_count("memory words written", wr_words - wr0, op.exp_wb ? BLOCK_WORDS : 0);
			check_count("memory words read", rd_words - rd0, op.exp_hit ? 0 : BLOCK_WORDS);
			ops_done++;
			$display("op %0d %s %h hit=%0b wb=%0b: %s", i, op.rw ? "store" : "load",
				op.addr, op.exp_hit, op.exp_wb, (errors == err0) ? "ok" : "errors");
		end
	endtask

	initial begin
		resetn     = 1'b0;
		core_req   = 1'b0;
		core_rw    = 1'b0;
		core_addr  = '0;
		core_wdata = '0;
		errors     = 0;
		checks     = 0;
		ops_done   = 0;
		timed_out  = 1'b0;
		m_rr       = 0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			shadow[a] = init_word(waddr_t'(a));
			m_mem[a]  = init_word(waddr_t'(a));
		end
		for (int i = 0; i < LINES; i++) begin
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
			m_lease[i] = 0;
			m_tag[i]   = '0;
		end

		// operation table
		add_op(1'b0, 16'h0010, '0);             // cold miss
		add_op(1'b0, 16'h0011, '0);             // same block, hit
		add_op(1'b1, 16'h0012, 32'h1234_5678);
		add_op(1'b0, 16'h0012, '0);
		for (int k = 0; k < 10; k++) begin     // more blocks than lines
			add_op(1'b1, waddr_t'(16'h0100 + 16'h0044 * k), word_t'(32'hd00d_0000 + k));
			if (k == 4)
				add_op(1'b0, 16'h0012, '0);     // renew an old line mid-way
		end
		for (int k = 0; k < 10; k++)
			add_op(1'b0, waddr_t'(16'h0100 + 16'h0044 * k), '0);
		add_op(1'b0, 16'h0012, '0);             // back from memory after write-back
		add_op(1'b1, 16'h0013, 32'h0bad_beef);
		add_op(1'b0, 16'h0013, '0);
		add_op(1'b0, 16'h0101, '0);
		for (int i = 0; i < ops.size(); i++)
			ops[i] = predict(ops[i]);

		repeat (2) @(negedge clock);
		check_bit("core_ack_o", core_ack, 1'b0);  // state right after reset
		check_bit("mem_req_o", mem_req, 1'b0);
		check_bit("flag_hit_o", flag_hit, 1'b0);
		check_bit("flag_miss_o", flag_miss, 1'b0);
		check_bit("flag_writeback_o", flag_wb, 1'b0);
		check_bit("flag_expired_o", flag_exp, 1'b0);
		resetn = 1'b1;

		for (int i = 0; i < ops.size() && !timed_out; i++)
			run_op(i);

		$display("%0d of %0d ops run, %0d checks, %0d errors",
			ops_done, ops.size(), checks, errors);
		if (errors == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
lease_cache_pkg.sv
lease_cache_ifs.sv
tag_cam.sv
line_store.sv
lease_policy.sv
mem_port.sv
cache_ctrl.sv
lease_cache_top.sv
tb_clock_gen.sv
tb_lease_cache.sv
